//--- hdl/exec_control.sv
module exec_control (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic [wasm_pkg::addr_width-1:0]      start_pc,
  output logic [wasm_pkg::addr_width-1:0]      mem_addr,
  input  logic [8*wasm_pkg::fetch_bytes-1:0]   mem_data,
  input  logic                                 push_stack,
  input  wasm_pkg::stack_entry_t               stack_in,
  stack_if.ctrl                                stack,
  input  logic [31:0]                          imm_value,
  input  logic [2:0]                           imm_length,
  input  wasm_pkg::stack_entry_t               alu_y,
  input  logic                                 alu_type_ok,
  output wasm_pkg::opcode_t                    opcode,
  output wasm_pkg::trap_t                      trap
);
  import wasm_pkg::*;

  step_t                 step;
  logic [addr_width-1:0] pc;
  logic [addr_width-1:0] pc_step;
  stack_op_t             cmd_op;
  stack_entry_t          cmd_data;
  trap_t                 fault;
  logic [31:0]           f32_bits;

  // Opcode is the top byte of the window
  assign opcode = opcode_t'(mem_data[8*fetch_bytes-1 -: 8]);

  // f32 immediate is stored little endian after the opcode
  assign f32_bits = {mem_data[15:8], mem_data[23:16], mem_data[31:24], mem_data[39:32]};

  // Decode and operand checks for the instruction in the window
  always_comb begin
    cmd_op   = SOP_NONE;
    cmd_data = alu_y;
    fault    = TRAP_NONE;
    pc_step  = addr_width'(1);
    case (opcode)
      OP_UNREACHABLE: fault = TRAP_UNREACHABLE;
      OP_NOP: begin
      end
      OP_END:         fault = TRAP_ENDED;
      OP_DROP: begin
        if (stack.count == '0) fault = TRAP_STACK_EMPTY;
        else cmd_op = SOP_POP;
      end
      OP_SELECT: begin
        if (stack.count < depth_t'(3)) begin
          fault = TRAP_STACK_EMPTY;
        end else if (stack.nos.tag != stack.third.tag || stack.tos.tag != TYPE_I32) begin
          fault = TRAP_TYPE_MISMATCH;
        end else begin
          cmd_op   = SOP_POP3_PUSH;
          cmd_data = (stack.tos.value != '0) ? stack.third : stack.nos;
        end
      end
      OP_I32_CONST: begin
        pc_step = addr_width'(imm_length) + addr_width'(1);
        cmd_data.tag   = TYPE_I32;
        cmd_data.value = imm_value;
        if (stack.count >= full_count) fault = TRAP_STACK_FULL;
        else cmd_op = SOP_PUSH;
      end
      OP_F32_CONST: begin
        pc_step = addr_width'(5);
        cmd_data.tag   = TYPE_F32;
        cmd_data.value = f32_bits;
        if (stack.count >= full_count) fault = TRAP_STACK_FULL;
        else cmd_op = SOP_PUSH;
      end
      OP_I32_EQZ, OP_I32_CLZ, OP_I32_CTZ, OP_I32_POPCNT,
      OP_I32_REINTERPRET_F32, OP_F32_REINTERPRET_I32: begin
        if (stack.count == '0) fault = TRAP_STACK_EMPTY;
        else if (!alu_type_ok) fault = TRAP_TYPE_MISMATCH;
        else cmd_op = SOP_REPLACE;
      end
      OP_I32_EQ, OP_I32_NE, OP_I32_LT_S, OP_I32_LT_U, OP_I32_GT_S,
      OP_I32_GT_U, OP_I32_LE_S, OP_I32_LE_U, OP_I32_GE_S, OP_I32_GE_U,
      OP_I32_ADD, OP_I32_SUB, OP_I32_MUL, OP_I32_AND, OP_I32_OR,
      OP_I32_XOR, OP_I32_SHL, OP_I32_SHR_S, OP_I32_SHR_U, OP_I32_ROTL,
      OP_I32_ROTR: begin
        if (stack.count < depth_t'(2)) fault = TRAP_STACK_EMPTY;
        else if (!alu_type_ok) fault = TRAP_TYPE_MISMATCH;
        else cmd_op = SOP_POP2_PUSH;
      end
      default: fault = TRAP_UNKNOWN_OPCODE;
    endcase
  end

  // Host push wins the cycle, a full stack drops it
  always_comb begin
    stack.op   = SOP_NONE;
    stack.data = cmd_data;
    if (push_stack) begin
      stack.data = stack_in;
      if (stack.count < full_count) stack.op = SOP_PUSH;
    end else if (step == EXEC && trap == TRAP_NONE && fault == TRAP_NONE) begin
      stack.op = cmd_op;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      step <= FETCH;
      pc   <= start_pc;
      trap <= TRAP_NONE;
    end else if (!push_stack && trap == TRAP_NONE) begin
      case (step)
        FETCH: step <= WAIT;
        // Window and stack views settle here
        WAIT:  step <= EXEC;
        EXEC: begin
          step <= FETCH;
          if (fault != TRAP_NONE) trap <= fault;
          else pc <= pc + pc_step;
        end
        default: step <= FETCH;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (step == FETCH) mem_addr <= pc;
  end

endmodule

//--- hdl/i32_alu.sv
module i32_alu (
  input  wasm_pkg::opcode_t      opcode,
  input  wasm_pkg::stack_entry_t a,
  input  wasm_pkg::stack_entry_t b,
  output wasm_pkg::stack_entry_t y,
  output logic                   type_ok
);
  import wasm_pkg::*;

  function automatic logic [31:0] clz32(input logic [31:0] v);
    logic [31:0] n;
    n = 32'd32;
    for (int i = 0; i < 32; i++) begin
      if (v[i]) n = 32'(31 - i);
    end
    return n;
  endfunction

  function automatic logic [31:0] ctz32(input logic [31:0] v);
    logic [31:0] n;
    n = 32'd32;
    for (int i = 31; i >= 0; i--) begin
      if (v[i]) n = 32'(i);
    end
    return n;
  endfunction

  function automatic logic [31:0] popcnt32(input logic [31:0] v);
    logic [31:0] n;
    n = '0;
    for (int i = 0; i < 32; i++) begin
      n = n + 32'(v[i]);
    end
    return n;
  endfunction

  logic [4:0]         sh;
  logic signed [31:0] sa;
  logic signed [31:0] sb;
  logic [63:0]        rot_l;
  logic [63:0]        rot_r;

  // Shift counts wrap at 32
  assign sh    = b.value[4:0];
  assign sa    = a.value;
  assign sb    = b.value;
  assign rot_l = {a.value, a.value} << sh;
  assign rot_r = {a.value, a.value} >> sh;

  always_comb begin
    y.tag   = TYPE_I32;
    y.value = '0;
    type_ok = (a.tag == TYPE_I32) && (b.tag == TYPE_I32);
    case (opcode)
      // Unary forms look at the top of stack only
      OP_I32_EQZ: begin
        y.value = {31'd0, b.value == '0};
        type_ok = b.tag == TYPE_I32;
      end
      OP_I32_CLZ: begin
        y.value = clz32(b.value);
        type_ok = b.tag == TYPE_I32;
      end
      OP_I32_CTZ: begin
        y.value = ctz32(b.value);
        type_ok = b.tag == TYPE_I32;
      end
      OP_I32_POPCNT: begin
        y.value = popcnt32(b.value);
        type_ok = b.tag == TYPE_I32;
      end
      OP_I32_REINTERPRET_F32: begin
        y.value = b.value;
        type_ok = b.tag == TYPE_F32;
      end
      OP_F32_REINTERPRET_I32: begin
        y.tag   = TYPE_F32;
        y.value = b.value;
        type_ok = b.tag == TYPE_I32;
      end
      OP_I32_EQ:    y.value = {31'd0, a.value == b.value};
      OP_I32_NE:    y.value = {31'd0, a.value != b.value};
      OP_I32_LT_S:  y.value = {31'd0, sa < sb};
      OP_I32_LT_U:  y.value = {31'd0, a.value < b.value};
      OP_I32_GT_S:  y.value = {31'd0, sa > sb};
      OP_I32_GT_U:  y.value = {31'd0, a.value > b.value};
      OP_I32_LE_S:  y.value = {31'd0, sa <= sb};
      OP_I32_LE_U:  y.value = {31'd0, a.value <= b.value};
      OP_I32_GE_S:  y.value = {31'd0, sa >= sb};
      OP_I32_GE_U:  y.value = {31'd0, a.value >= b.value};
      OP_I32_ADD:   y.value = a.value + b.value;
      OP_I32_SUB:   y.value = a.value - b.value;
      OP_I32_MUL:   y.value = a.value * b.value;
      OP_I32_AND:   y.value = a.value & b.value;
      OP_I32_OR:    y.value = a.value | b.value;
      OP_I32_XOR:   y.value = a.value ^ b.value;
      OP_I32_SHL:   y.value = a.value << sh;
      OP_I32_SHR_S: y.value = 32'(sa >>> sh);
      OP_I32_SHR_U: y.value = a.value >> sh;
      OP_I32_ROTL:  y.value = rot_l[63:32];
      OP_I32_ROTR:  y.value = rot_r[31:0];
      default:      type_ok = 1'b1;
    endcase
  end

endmodule

//--- hdl/leb128_decoder.sv
module leb128_decoder (
  input  logic [39:0] bytes,
  output logic [31:0] value,
  output logic [2:0]  length
);

  // First byte sits in the top bits
  logic [4:0]  cont;
  logic [34:0] raw;

  for (genvar i = 0; i < 5; i++) begin : g_byte
    assign cont[i]         = bytes[39 - 8*i];
    assign raw[7*i +: 7]   = bytes[38 - 8*i -: 7];
  end

  // Lowest byte with a clear continuation bit ends the number
  always_comb begin
    length = 3'd5;
    for (int i = 4; i >= 0; i--) begin
      if (!cont[i]) begin
        length = 3'(i + 1);
      end
    end
  end

  // Sign comes from bit 6 of the last group
  always_comb begin
    case (length)
      3'd1:    value = {{25{raw[6]}}, raw[6:0]};
      3'd2:    value = {{18{raw[13]}}, raw[13:0]};
      3'd3:    value = {{11{raw[20]}}, raw[20:0]};
      3'd4:    value = {{4{raw[27]}}, raw[27:0]};
      // Fifth group only adds the top four bits
      default: value = raw[31:0];
    endcase
  end

endmodule

//--- hdl/operand_stack.sv
module operand_stack (
  input logic   clk,
  input logic   reset,
  stack_if.stk  stack
);
  import wasm_pkg::*;

  stack_entry_t entries [stack_depth];
  depth_t       count;

  index_t push_idx;
  index_t tos_idx;
  index_t nos_idx;
  index_t third_idx;

  // Slot positions relative to the current fill level
  assign push_idx  = index_t'(count);
  assign tos_idx   = index_t'(count - depth_t'(1));
  assign nos_idx   = index_t'(count - depth_t'(2));
  assign third_idx = index_t'(count - depth_t'(3));

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else begin
      case (stack.op)
        SOP_PUSH:      count <= count + depth_t'(1);
        SOP_POP:       count <= count - depth_t'(1);
        // Two operands in, one result out
        SOP_POP2_PUSH: count <= count - depth_t'(1);
        SOP_POP3_PUSH: count <= count - depth_t'(2);
        default: begin
        end
      endcase
    end
  end

  // New entry lands where the collapsed group began
  always_ff @(posedge clk) begin
    case (stack.op)
      SOP_PUSH:      entries[push_idx]  <= stack.data;
      SOP_REPLACE:   entries[tos_idx]   <= stack.data;
      SOP_POP2_PUSH: entries[nos_idx]   <= stack.data;
      SOP_POP3_PUSH: entries[third_idx] <= stack.data;
      default: begin
      end
    endcase
  end

  // Views are only meaningful when count covers them
  assign stack.tos   = entries[tos_idx];
  assign stack.nos   = entries[nos_idx];
  assign stack.third = entries[third_idx];
  assign stack.count = count;

endmodule

//--- hdl/stack_if.sv
interface stack_if;
  import wasm_pkg::*;

  // Command from the controller
  stack_op_t    op;
  stack_entry_t data;

  // Top three entries and fill level
  stack_entry_t tos;
  stack_entry_t nos;
  stack_entry_t third;
  depth_t       count;

  modport ctrl (output op, data, input tos, nos, third, count);
  modport stk (input op, data, output tos, nos, third, count);

endinterface

//--- hdl/wasm_cpu.sv
module wasm_cpu (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic [wasm_pkg::addr_width-1:0]      start_pc,
  output logic [wasm_pkg::addr_width-1:0]      mem_addr,
  input  logic [8*wasm_pkg::fetch_bytes-1:0]   mem_data,
  input  logic                                 push_stack,
  input  wasm_pkg::stack_entry_t               stack_in,
  output logic [31:0]                          result,
  output wasm_pkg::value_type_t                result_type,
  output logic                                 result_empty,
  output wasm_pkg::trap_t                      trap
);
  import wasm_pkg::*;

  stack_if stack_bus ();

  opcode_t      opcode;
  logic [31:0]  imm_value;
  logic [2:0]   imm_length;
  stack_entry_t alu_y;
  logic         alu_type_ok;

  operand_stack u_stack (
    .clk   (clk),
    .reset (reset),
    .stack (stack_bus.stk)
  );

  // Immediate bytes follow the opcode byte
  leb128_decoder u_leb128 (
    .bytes  (mem_data[8*fetch_bytes-9:0]),
    .value  (imm_value),
    .length (imm_length)
  );

  i32_alu u_alu (
    .opcode  (opcode),
    .a       (stack_bus.nos),
    .b       (stack_bus.tos),
    .y       (alu_y),
    .type_ok (alu_type_ok)
  );

  exec_control u_ctrl (
    .clk         (clk),
    .reset       (reset),
    .start_pc    (start_pc),
    .mem_addr    (mem_addr),
    .mem_data    (mem_data),
    .push_stack  (push_stack),
    .stack_in    (stack_in),
    .stack       (stack_bus.ctrl),
    .imm_value   (imm_value),
    .imm_length  (imm_length),
    .alu_y       (alu_y),
    .alu_type_ok (alu_type_ok),
    .opcode      (opcode),
    .trap        (trap)
  );

  assign result       = stack_bus.tos.value;
  assign result_type  = stack_bus.tos.tag;
  assign result_empty = stack_bus.count == '0;

endmodule

//--- hdl/wasm_pkg.sv
package wasm_pkg;

  localparam int addr_width  = 16;
  localparam int stack_depth = 16;
  localparam int index_width = $clog2(stack_depth);
  // Opcode byte plus up to five immediate bytes
  localparam int fetch_bytes = 6;

  typedef logic [$clog2(stack_depth+1)-1:0] depth_t;
  typedef logic [index_width-1:0] index_t;

  localparam depth_t full_count = depth_t'(stack_depth);

  // Tags follow 0x7f minus the Wasm value type byte
  typedef enum logic [1:0] {
    TYPE_I32 = 2'd0,
    TYPE_F32 = 2'd2
  } value_type_t;

  typedef struct packed {
    value_type_t tag;
    logic [31:0] value;
  } stack_entry_t;

  typedef enum logic [7:0] {
    OP_UNREACHABLE         = 8'h00,
    OP_NOP                 = 8'h01,
    OP_END                 = 8'h0b,
    OP_DROP                = 8'h1a,
    OP_SELECT              = 8'h1b,
    OP_I32_CONST           = 8'h41,
    OP_F32_CONST           = 8'h43,
    OP_I32_EQZ             = 8'h45,
    OP_I32_EQ              = 8'h46,
    OP_I32_NE              = 8'h47,
    OP_I32_LT_S            = 8'h48,
    OP_I32_LT_U            = 8'h49,
    OP_I32_GT_S            = 8'h4a,
    OP_I32_GT_U            = 8'h4b,
    OP_I32_LE_S            = 8'h4c,
    OP_I32_LE_U            = 8'h4d,
    OP_I32_GE_S            = 8'h4e,
    OP_I32_GE_U            = 8'h4f,
    OP_I32_CLZ             = 8'h67,
    OP_I32_CTZ             = 8'h68,
    OP_I32_POPCNT          = 8'h69,
    OP_I32_ADD             = 8'h6a,
    OP_I32_SUB             = 8'h6b,
    OP_I32_MUL             = 8'h6c,
    OP_I32_AND             = 8'h71,
    OP_I32_OR              = 8'h72,
    OP_I32_XOR             = 8'h73,
    OP_I32_SHL             = 8'h74,
    OP_I32_SHR_S           = 8'h75,
    OP_I32_SHR_U           = 8'h76,
    OP_I32_ROTL            = 8'h77,
    OP_I32_ROTR            = 8'h78,
    OP_I32_REINTERPRET_F32 = 8'hbc,
    OP_F32_REINTERPRET_I32 = 8'hbe
  } opcode_t;

  typedef enum logic [3:0] {
    TRAP_NONE           = 4'd0,
    TRAP_ENDED          = 4'd1,
    TRAP_UNREACHABLE    = 4'd2,
    TRAP_UNKNOWN_OPCODE = 4'd3,
    TRAP_TYPE_MISMATCH  = 4'd4,
    TRAP_STACK_EMPTY    = 4'd5,
    TRAP_STACK_FULL     = 4'd6
  } trap_t;

  typedef enum logic [2:0] {
    SOP_NONE,
    SOP_PUSH,
    SOP_POP,
    SOP_REPLACE,
    SOP_POP2_PUSH,
    SOP_POP3_PUSH
  } stack_op_t;

  typedef enum logic [1:0] {
    FETCH,
    WAIT,
    EXEC
  } step_t;

endpackage

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module wasm_cpu_tb -f sim.f -o wasm_cpu_sim
output=$(./obj_dir/wasm_cpu_sim 2>&1) || true
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -q "TESTBENCH PASSED"; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

//--- sim.f
hdl/wasm_pkg.sv
hdl/stack_if.sv
hdl/operand_stack.sv
hdl/leb128_decoder.sv
hdl/i32_alu.sv
hdl/exec_control.sv
hdl/wasm_cpu.sv
tests/wasm_rom.sv
tests/wasm_cpu_tb.sv

//--- tests/wasm_cpu_tb.sv
module wasm_cpu_tb;
  import wasm_pkg::*;

  logic                     clk;
  logic                     reset;
  logic [addr_width-1:0]    start_pc;
  logic [addr_width-1:0]    mem_addr;
  logic [8*fetch_bytes-1:0] mem_data;
  logic                     push_stack;
  stack_entry_t             stack_in;
  logic [31:0]              result;
  value_type_t              result_type;
  logic                     result_empty;
  trap_t                    trap;

  integer     seed;
  logic [7:0] prog [$];
  opcode_t    binary_ops [21] = '{OP_I32_EQ, OP_I32_NE, OP_I32_LT_S, OP_I32_LT_U,
    OP_I32_GT_S, OP_I32_GT_U, OP_I32_LE_S, OP_I32_LE_U, OP_I32_GE_S, OP_I32_GE_U,
    OP_I32_ADD, OP_I32_SUB, OP_I32_MUL, OP_I32_AND, OP_I32_OR, OP_I32_XOR, OP_I32_SHL,
    OP_I32_SHR_S, OP_I32_SHR_U, OP_I32_ROTL, OP_I32_ROTR};
  opcode_t    unary_ops [4] = '{OP_I32_EQZ, OP_I32_CLZ, OP_I32_CTZ, OP_I32_POPCNT};
  // One to five LEB128 bytes, both signs
  logic [31:0] const_values [12] = '{32'd5, 32'hfffffffd, 32'd64, 32'hffffffc0, 32'd200,
    32'hfffffc18, 32'd100000, 32'hfff0bdc0, 32'h01000000, 32'hf8000000, 32'h7fffffff,
    32'h80000000};

  wasm_cpu DUT (.*);
  wasm_rom ROM (.addr(mem_addr), .data(mem_data));

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      stop_with_failure($sformatf("Fail at time %0t: %s is %h, expected %h",
                                  $time, what, got, exp));
    end
  endtask

  task automatic check_trap(input trap_t exp);
    assert (trap == exp) else begin
      stop_with_failure($sformatf("Fail at time %0t: trap is %s, expected %s",
                                  $time, trap.name(), exp.name()));
    end
  endtask

  task automatic push_entry(input value_type_t tag, input logic [31:0] v);
    push_stack     = 1'b1;
    stack_in.tag   = tag;
    stack_in.value = v;
    @(posedge clk);
    #1;
    push_stack = 1'b0;
  endtask

  task automatic add_op(input opcode_t op);
    prog.push_back(op);
  endtask

  // Signed LEB128, seven bits per byte until only sign bits remain
  task automatic add_i32_const(input logic [31:0] v);
    logic signed [31:0] rest;
    logic [7:0]         group;
    logic               done;
    rest = v;
    done = 1'b0;
    add_op(OP_I32_CONST);
    while (!done) begin
      group = {1'b0, rest[6:0]};
      rest  = rest >>> 7;
      done  = (rest == 0 && !group[6]) || (rest == -1 && group[6]);
      if (!done) group[7] = 1'b1;
      prog.push_back(group);
    end
  endtask

  task automatic add_f32_const(input logic [31:0] bits);
    add_op(OP_F32_CONST);
    prog.push_back(bits[7:0]);
    prog.push_back(bits[15:8]);
    prog.push_back(bits[23:16]);
    prog.push_back(bits[31:24]);
  endtask

  task automatic start_program();
    reset = 1'b1;
    foreach (prog[i]) begin
      ROM.load_byte(start_pc + addr_width'(i), prog[i]);
    end
    prog.delete();
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
  endtask

  task automatic wait_for_trap();
    int cycles;
    cycles = 0;
    while (trap == TRAP_NONE && cycles < 400) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (trap == TRAP_NONE) stop_with_failure("Timeout: the core never stopped on a trap");
  endtask

  task automatic run_to_trap(input trap_t exp_trap);
    start_program();
    wait_for_trap();
    check_trap(exp_trap);
  endtask

  task automatic run_and_check(input trap_t exp_trap, input logic [31:0] exp_value,
                               input value_type_t exp_type);
    run_to_trap(exp_trap);
    check_value("result", result, exp_value);
    check_value("result_type", 32'(result_type), 32'(exp_type));
  endtask

  function automatic logic [31:0] binary_rule(input opcode_t op, input logic [31:0] a,
                                              input logic [31:0] b);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic [4:0]         s;
    sa = a;
    sb = b;
    s  = b[4:0];
    case (op)
      OP_I32_EQ:    return (a == b) ? 32'd1 : 32'd0;
      OP_I32_NE:    return (a != b) ? 32'd1 : 32'd0;
      OP_I32_LT_S:  return (sa < sb) ? 32'd1 : 32'd0;
      OP_I32_LT_U:  return (a < b) ? 32'd1 : 32'd0;
      OP_I32_GT_S:  return (sa > sb) ? 32'd1 : 32'd0;
      OP_I32_GT_U:  return (a > b) ? 32'd1 : 32'd0;
      OP_I32_LE_S:  return (sa <= sb) ? 32'd1 : 32'd0;
      OP_I32_LE_U:  return (a <= b) ? 32'd1 : 32'd0;
      OP_I32_GE_S:  return (sa >= sb) ? 32'd1 : 32'd0;
      OP_I32_GE_U:  return (a >= b) ? 32'd1 : 32'd0;
      OP_I32_ADD:   return a + b;
      OP_I32_SUB:   return a - b;
      OP_I32_MUL:   return a * b;
      OP_I32_AND:   return a & b;
      OP_I32_OR:    return a | b;
      OP_I32_XOR:   return a ^ b;
      OP_I32_SHL:   return a << s;
      OP_I32_SHR_S: return sa >>> s;
      OP_I32_SHR_U: return a >> s;
      // A shift by 32 gives zero, so a zero amount needs no special case
      OP_I32_ROTL:  return (a << s) | (a >> (6'd32 - {1'b0, s}));
      OP_I32_ROTR:  return (a >> s) | (a << (6'd32 - {1'b0, s}));
      default:      return 32'd0;
    endcase
  endfunction

  function automatic logic [31:0] unary_rule(input opcode_t op, input logic [31:0] v);
    logic [31:0] t;
    int          n;
    t = v;
    n = 0;
    case (op)
      OP_I32_EQZ: n = (v == 0) ? 1 : 0;
      OP_I32_CLZ: begin
        while (n < 32 && !t[31]) begin
          t = t << 1;
          n++;
        end
      end
      OP_I32_CTZ: begin
        while (n < 32 && !t[0]) begin
          t = t >> 1;
          n++;
        end
      end
      default: n = $countones(v);
    endcase
    return 32'(n);
  endfunction

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    seed       = 32'h3d0fda68;
    reset      = 1'b1;
    start_pc   = 16'h0120;
    push_stack = 1'b0;
    stack_in   = '0;
    @(posedge clk);
    #1;

    // Host pushes while a run of nops executes
    repeat (6) add_op(OP_NOP);
    add_op(OP_END);
    start_program();
    a = $random(seed);
    b = $random(seed);
    push_entry(TYPE_I32, a);
    push_entry(TYPE_F32, b);
    check_value("result", result, b);
    check_value("result_type", 32'(result_type), 32'(TYPE_F32));
    check_value("result_empty", 32'(result_empty), 32'd0);
    wait_for_trap();
    check_trap(TRAP_ENDED);
    push_entry(TYPE_I32, a);
    check_value("result", result, a);
    reset = 1'b1;
    @(posedge clk);
    #1;
    check_value("result_empty", 32'(result_empty), 32'd1);

    foreach (const_values[i]) begin
      add_i32_const(const_values[i]);
      add_op(OP_END);
      run_and_check(TRAP_ENDED, const_values[i], TYPE_I32);
    end

    // Third pass uses equal operands
    foreach (binary_ops[i]) begin
      for (int j = 0; j < 3; j++) begin
        a = $random(seed);
        if (j == 2) begin
          b = a;
        end else begin
          b = $random(seed);
        end
        add_i32_const(a);
        add_i32_const(b);
        add_op(binary_ops[i]);
        add_op(OP_END);
        run_and_check(TRAP_ENDED, binary_rule(binary_ops[i], a, b), TYPE_I32);
      end
    end

    foreach (unary_ops[i]) begin
      for (int j = 0; j < 3; j++) begin
        a = $random(seed);
        if (j == 0) a = '0;
        if (j == 2) a = (a >> a[4:0]) << a[9:5];
        add_i32_const(a);
        add_op(unary_ops[i]);
        add_op(OP_END);
        run_and_check(TRAP_ENDED, unary_rule(unary_ops[i], a), TYPE_I32);
      end
    end

    // Non-zero condition picks the deeper candidate
    for (int j = 0; j < 4; j++) begin
      a = $random(seed);
      b = $random(seed);
      c = $random(seed) | 32'd1;
      if (j % 2 == 0) c = '0;
      add_i32_const(a);
      add_i32_const(b);
      add_i32_const(c);
      add_op(OP_SELECT);
      add_op(OP_END);
      run_and_check(TRAP_ENDED, (c != 0) ? a : b, TYPE_I32);
    end
    add_i32_const(a);
    add_i32_const(b);
    add_op(OP_DROP);
    add_op(OP_END);
    run_and_check(TRAP_ENDED, a, TYPE_I32);

    add_i32_const(a);
    add_f32_const(b);
    add_op(OP_I32_ADD);
    run_to_trap(TRAP_TYPE_MISMATCH);
    add_f32_const(b);
    add_op(OP_END);
    run_and_check(TRAP_ENDED, b, TYPE_F32);
    add_f32_const(b);
    add_op(OP_I32_REINTERPRET_F32);
    add_op(OP_END);
    run_and_check(TRAP_ENDED, b, TYPE_I32);
    add_i32_const(a);
    add_op(OP_F32_REINTERPRET_I32);
    add_op(OP_END);
    run_and_check(TRAP_ENDED, a, TYPE_F32);

    add_op(OP_UNREACHABLE);
    run_to_trap(TRAP_UNREACHABLE);
    prog.push_back(8'h10);
    run_to_trap(TRAP_UNKNOWN_OPCODE);
    add_op(OP_I32_ADD);
    run_to_trap(TRAP_STACK_EMPTY);
    // Sixteen entries fit and the seventeenth push traps
    for (int i = 0; i < 17; i++) add_i32_const(32'(i * 3));
    run_and_check(TRAP_STACK_FULL, 32'd45, TYPE_I32);
    check_value("result_empty", 32'(result_empty), 32'd0);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- tests/wasm_rom.sv
module wasm_rom (
  input  logic [wasm_pkg::addr_width-1:0]    addr,
  output logic [8*wasm_pkg::fetch_bytes-1:0] data
);
  import wasm_pkg::*;

  logic [7:0] image [2**addr_width];

  // Background bytes mix both halves of the address
  initial begin
    logic [addr_width-1:0] a;
    a = '0;
    do begin
      image[a] = a[7:0] ^ a[addr_width-1 -: 8] ^ 8'h5a;
      a++;
    end while (a != '0);
  end

  // Byte at addr lands in the top lane, the window wraps at the end of memory
  for (genvar k = 0; k < fetch_bytes; k++) begin : g_lane
    assign data[8*(fetch_bytes-1-k) +: 8] = image[addr + addr_width'(k)];
  end

  task automatic load_byte(input logic [addr_width-1:0] a, input logic [7:0] v);
    image[a] = v;
  endtask

endmodule
